/* common/xsl_bus_pkg.sv */
// Accelerator link bus definitions
//   data word width
//   opcode and immediate field widths
//   immediate control bit positions
//   GET/PUT opcode match and put-data marker
package xsl_bus_pkg;

   // Widths
   localparam int XSL_DW = 32;            // Bus data word
   localparam int OPC_W  = 6;             // Instruction opcode
   localparam int IMM_W  = 16;            // Instruction immediate

   // Immediate field bits
   localparam int IMM_WRE_BIT  = 15;      // Set for PUT, clear for GET
   localparam int IMM_NBLK_BIT = 14;      // Non-blocking form
   localparam int IMM_CTL_BIT  = 13;      // Control form, carries the tag

   // GET/PUT decode on opcode bits 5:3
   localparam int OPC_GP_MSB = 5;
   localparam int OPC_GP_LSB = 3;
   // Bit 5 clear, bits 4 and 3 set
   localparam logic [OPC_GP_MSB-OPC_GP_LSB:0] OPC_GETPUT = 3'b011;

   // Opcode bits 1:0 at this value mean the operand is write data
   localparam logic [1:0] OPC_PUTDATA_BITS = 2'b11;

endpackage

/* common/mbox_pkg.sv */
// Mailbox definitions
//   default channel count and FIFO depth
//   stored FIFO entry, data word plus control tag
package mbox_pkg;

   // Defaults picked up by the top level
   localparam int MBOX_NCH_DEF   = 4;     // Mailbox channels
   localparam int MBOX_DEPTH_DEF = 4;     // Words per channel FIFO

   // One FIFO entry, 33 bits
   typedef struct packed {
      logic [xsl_bus_pkg::XSL_DW-1:0] data;  // Payload word
      logic                           tag;   // Set when written by a control PUT
   } mbox_entry_t;

endpackage

/* xslif/xsl_link.sv */
// Accelerator link
//   turns GET/PUT instructions into strobe/ack bus cycles
//   strobe runs independent of the pipeline once issued
//   feedback to the pipeline, read latch and read result register
`timescale 1ns/1ps

module xsl_link #(
   parameter int CH_BITS = 3                          // Channel address width
) (
   input  logic                             gclk,
   input  logic                             grst,
   input  logic                             dena_i,  // Pipeline advance
   input  logic [xsl_bus_pkg::OPC_W-1:0]    opc_i,
   input  logic [xsl_bus_pkg::IMM_W-1:0]    imm_i,
   input  logic [xsl_bus_pkg::XSL_DW-1:0]   opa_i,
   input  logic                             ack_i,   // Merged channel ack
   input  logic [xsl_bus_pkg::XSL_DW-1:0]   rdat_i,  // Merged channel read data
   output logic                             stb_o,
   output logic [CH_BITS-1:0]               adr_o,
   output logic                             wre_o,
   output logic                             tag_o,
   output logic                             nblk_o,
   output logic [xsl_bus_pkg::XSL_DW-1:0]   wdat_o,
   output logic                             fb_o,    // Pipeline may advance
   output logic [xsl_bus_pkg::XSL_DW-1:0]   mx_o     // Read result
);

   logic                           is_getput;   // Opcode is GET/PUT
   logic                           is_putdata;  // Operand carries write data
   logic                           rd_take;     // Acked bus cycle ends this edge
   logic [xsl_bus_pkg::XSL_DW-1:0] rd_lat;      // Last acked read data

   // Opcode decode
   assign is_getput  = (opc_i[xsl_bus_pkg::OPC_GP_MSB:xsl_bus_pkg::OPC_GP_LSB]
                        == xsl_bus_pkg::OPC_GETPUT);
   assign is_putdata = (opc_i[1:0] == xsl_bus_pkg::OPC_PUTDATA_BITS);

   assign rd_take = stb_o & ack_i;

   // Feedback, idle bus or a cycle finishing now
   // Non-blocking form is done in its first strobe cycle
   assign fb_o = !stb_o | ack_i | nblk_o;

   // Strobe, loaded on pipeline advance only
   always_ff @(posedge gclk) begin
      if (grst) begin
         stb_o <= 1'b0;
      end else if (dena_i) begin
         stb_o <= is_getput;
      end else if (ack_i | nblk_o) begin
         stb_o <= 1'b0;                               // Cycle finished
      end
   end

   // Bus fields from the immediate
   always_ff @(posedge gclk) begin
      if (grst) begin
         adr_o  <= '0;
         wre_o  <= 1'b0;
         tag_o  <= 1'b0;
         nblk_o <= 1'b0;
      end else if (dena_i) begin
         adr_o  <= imm_i[CH_BITS-1:0];                // Channel number
         wre_o  <= imm_i[xsl_bus_pkg::IMM_WRE_BIT];   // PUT
         nblk_o <= imm_i[xsl_bus_pkg::IMM_NBLK_BIT];  // nGET/nPUT
         tag_o  <= imm_i[xsl_bus_pkg::IMM_CTL_BIT];   // cGET/cPUT
      end
   end

   // Write data, held unless a new put operand arrives
   always_ff @(posedge gclk) begin
      if (dena_i && is_putdata) begin
         wdat_o <= opa_i;
      end
   end

   // Read latch
   // Unacked non-blocking cycles leave it alone
   always_ff @(posedge gclk) begin
      if (grst) begin
         rd_lat <= '0;
      end else if (rd_take) begin
         rd_lat <= rdat_i;
      end
   end

   // Read result towards the pipeline
   always_ff @(posedge gclk) begin
      if (grst) begin
         mx_o <= '0;
      end else if (dena_i) begin
         mx_o <= rd_take ? rdat_i : rd_lat;           // Fresh data or latched copy
      end
   end

endmodule

/* source/chan_decode.sv */
// Channel decoder
//   one-hot strobe per mailbox channel from the bus address
//   out-of-range addresses strobe nothing
`timescale 1ns/1ps

module chan_decode #(
   parameter int NCH     = 4,                   // Channels present
   parameter int CH_BITS = 3                    // Address field width
) (
   input  logic               stb_i,            // Bus strobe from the link
   input  logic [CH_BITS-1:0] adr_i,            // Channel address
   output logic [NCH-1:0]     chan_stb_o        // One strobe per channel
);

   // Address match per channel
   // Addresses at or above NCH fall through with every bit clear
   always_comb begin
      chan_stb_o = '0;
      for (int i = 0; i < NCH; i++) begin
         if (stb_i && (adr_i == CH_BITS'(i))) begin
            chan_stb_o[i] = 1'b1;
         end
      end
   end

endmodule

/* source/mbox_chan.sv */
// Mailbox channel
//   circular FIFO of data words with their control tag
//   combinational ack during strobe, full/empty from a count
//   sticky flag on a GET whose tag differs from the stored one
`timescale 1ns/1ps

module mbox_chan #(
   parameter int DEPTH = 4                              // FIFO entries
) (
   input  logic                           gclk,
   input  logic                           grst,
   input  logic                           stb_i,        // This channel addressed
   input  logic                           wre_i,        // PUT when set
   input  logic                           tag_i,        // Control form
   input  logic [xsl_bus_pkg::XSL_DW-1:0] wdat_i,
   output logic                           ack_o,
   output logic [xsl_bus_pkg::XSL_DW-1:0] rdat_o,
   output logic                           err_o         // Sticky tag mismatch
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   mbox_pkg::mbox_entry_t mem [DEPTH];                  // Storage, no reset

   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             empty;
   logic             push;
   logic             pop;

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // PUT needs room, GET needs a word
   assign ack_o = stb_i & (wre_i ? !full : !empty);
   assign push  = ack_o & wre_i;
   assign pop   = ack_o & !wre_i;

   // Head word, only while a GET is served
   assign rdat_o = pop ? mem[rd_ptr].data : '0;

   // Write side
   always_ff @(posedge gclk) begin
      if (push) begin
         mem[wr_ptr].data <= wdat_i;
         mem[wr_ptr].tag  <= tag_i;                     // Remember the form
      end
   end

   // Pointers and count
   always_ff @(posedge gclk) begin
      if (grst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Only one of push and pop per strobe
         if (push) begin
            count <= count + 1'b1;
         end else if (pop) begin
            count <= count - 1'b1;
         end
      end
   end

   // Tag check on pop
   // Word still leaves the FIFO on a mismatch
   always_ff @(posedge gclk) begin
      if (grst) begin
         err_o <= 1'b0;
      end else if (pop && (mem[rd_ptr].tag != tag_i)) begin
         err_o <= 1'b1;                                 // Held until reset
      end
   end

endmodule

/* source/resp_merge.sv */
// Response merger
//   OR of channel acks
//   read data of the strobed channel, zero when none strobed
`timescale 1ns/1ps

module resp_merge #(
   parameter int NCH = 4                                       // Channels present
) (
   input  logic [NCH-1:0]                        chan_ack_i,
   input  logic [NCH*xsl_bus_pkg::XSL_DW-1:0]    chan_rdat_i,  // Channel 0 in low word
   input  logic [NCH-1:0]                        chan_stb_i,   // One-hot or zero
   output logic                                  ack_o,
   output logic [xsl_bus_pkg::XSL_DW-1:0]        rdat_o
);

   // Single strobed channel, so a plain OR is enough
   assign ack_o = |chan_ack_i;

   // Data select by strobe
   always_comb begin
      rdat_o = '0;
      for (int i = 0; i < NCH; i++) begin
         if (chan_stb_i[i]) begin
            rdat_o = chan_rdat_i[i*xsl_bus_pkg::XSL_DW +: xsl_bus_pkg::XSL_DW];
         end
      end
   end

endmodule

/* source/xsl_subsys_top.sv */
// Accelerator link subsystem
//   link, channel decoder, mailbox channels, response merger
//   pipeline handshake through dena_i and fb_o
`timescale 1ns/1ps

module xsl_subsys_top #(
   parameter int NCH   = mbox_pkg::MBOX_NCH_DEF,       // Mailbox channels
   parameter int DEPTH = mbox_pkg::MBOX_DEPTH_DEF      // Words per channel
) (
   input  logic                           gclk,
   input  logic                           grst,
   input  logic                           dena_i,
   input  logic [xsl_bus_pkg::OPC_W-1:0]  opc_i,
   input  logic [xsl_bus_pkg::IMM_W-1:0]  imm_i,
   input  logic [xsl_bus_pkg::XSL_DW-1:0] opa_i,
   output logic                           fb_o,
   output logic [xsl_bus_pkg::XSL_DW-1:0] mx_o,
   output logic [NCH-1:0]                 err_o        // One sticky bit per channel
);

   // One spare address bit so out-of-range channels can be named
   localparam int CH_BITS = $clog2(NCH) + 1;

   // Link bus
   logic                               stb;
   logic [CH_BITS-1:0]                 adr;
   logic                               wre;
   logic                               tag;
   logic [xsl_bus_pkg::XSL_DW-1:0]     wdat;
   logic                               ack;
   logic [xsl_bus_pkg::XSL_DW-1:0]     rdat;

   // Per-channel wires
   logic [NCH-1:0]                     chan_stb;
   logic [NCH-1:0]                     chan_ack;
   logic [NCH*xsl_bus_pkg::XSL_DW-1:0] chan_rdat;

   xsl_link #(.CH_BITS(CH_BITS)) u_link (
      .gclk   (gclk),
      .grst   (grst),
      .dena_i (dena_i),
      .opc_i  (opc_i),
      .imm_i  (imm_i),
      .opa_i  (opa_i),
      .ack_i  (ack),
      .rdat_i (rdat),
      .stb_o  (stb),
      .adr_o  (adr),
      .wre_o  (wre),
      .tag_o  (tag),
      .nblk_o (),               // Channels just withhold ack, link ends the cycle
      .wdat_o (wdat),
      .fb_o   (fb_o),
      .mx_o   (mx_o)
   );

   chan_decode #(.NCH(NCH), .CH_BITS(CH_BITS)) u_dec (
      .stb_i      (stb),
      .adr_i      (adr),
      .chan_stb_o (chan_stb)
   );

   // Mailbox channels, write fields shared
   for (genvar g = 0; g < NCH; g++) begin : g_chan
      mbox_chan #(.DEPTH(DEPTH)) u_chan (
         .gclk   (gclk),
         .grst   (grst),
         .stb_i  (chan_stb[g]),
         .wre_i  (wre),
         .tag_i  (tag),
         .wdat_i (wdat),
         .ack_o  (chan_ack[g]),
         .rdat_o (chan_rdat[g*xsl_bus_pkg::XSL_DW +: xsl_bus_pkg::XSL_DW]),
         .err_o  (err_o[g])
      );
   end

   resp_merge #(.NCH(NCH)) u_merge (
      .chan_ack_i  (chan_ack),
      .chan_rdat_i (chan_rdat),
      .chan_stb_i  (chan_stb),
      .ack_o       (ack),
      .rdat_o      (rdat)
   );

endmodule

/* tb/tb_xsl_subsys.sv */
// Testbench for the accelerator link subsystem
//   clock, reset and input setup
//   stimulus table built from an LCG, expected values from a queue model
//   table applied row by row through the dena_i/fb_o handshake
//   watchdog and closing summary
`timescale 1ns/1ps

module tb_xsl_subsys;

   localparam int NCH        = 4;
   localparam int DEPTH      = 4;
   localparam int CLK_PERIOD = 100;                  // ns
   localparam int FB_WAIT    = 20;                   // Cycles allowed for fb_o

   // Opcodes built from the bus field rules
   localparam logic [5:0] OPC_PUT = {xsl_bus_pkg::OPC_GETPUT, 1'b0,
                                     xsl_bus_pkg::OPC_PUTDATA_BITS};
   localparam logic [5:0] OPC_GET = {xsl_bus_pkg::OPC_GETPUT, 3'b000};
   localparam logic [5:0] OPC_NOP = 6'b000000;      // Not GET/PUT

   logic              gclk;
   logic              grst;
   logic              dena_i;
   logic [5:0]        opc_i;
   logic [15:0]       imm_i;
   logic [31:0]       opa_i;
   logic              fb_o;
   logic [31:0]       mx_o;
   logic [NCH-1:0]    err_o;

   // Stimulus table, one entry per row in each queue
   string             row_name [$];
   bit                row_put  [$];
   bit                row_nblk [$];
   bit                row_ctl  [$];
   int                row_ch   [$];
   logic [31:0]       row_data [$];
   logic [31:0]       exp_mx   [$];
   logic [NCH-1:0]    exp_err  [$];

   mbox_pkg::mbox_entry_t model_q [NCH][$];          // Reference FIFO per channel

   logic [31:0]       rng_state = 32'h2aad;
   bit                table_ready = 1'b0;
   int                errors = 0;
   int                checks = 0;

   xsl_subsys_top #(.NCH(NCH), .DEPTH(DEPTH)) UUT (
      .gclk   (gclk),
      .grst   (grst),
      .dena_i (dena_i),
      .opc_i  (opc_i),
      .imm_i  (imm_i),
      .opa_i  (opa_i),
      .fb_o   (fb_o),
      .mx_o   (mx_o),
      .err_o  (err_o)
   );

   initial begin
      gclk = 1'b0;
      forever #(CLK_PERIOD / 2) gclk = ~gclk;
   end

   // Next LCG value
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Immediate with form bits and channel address
   function automatic logic [15:0] make_imm(input bit put, input bit nblk,
                                            input bit ctl, input int ch);
      logic [15:0] v;
      v = '0;
      v[xsl_bus_pkg::IMM_WRE_BIT]  = put;
      v[xsl_bus_pkg::IMM_NBLK_BIT] = nblk;
      v[xsl_bus_pkg::IMM_CTL_BIT]  = ctl;
      v[2:0] = ch[2:0];                              // Address field, 3 bits for 4 channels
      return v;
   endfunction

   task automatic add_row(input string name, input bit put, input bit nblk,
                          input bit ctl, input int ch);
      row_name.push_back(name);
      row_put.push_back(put);
      row_nblk.push_back(nblk);
      row_ctl.push_back(ctl);
      row_ch.push_back(ch);
      if (put) begin
         rng_state = lcg_step(rng_state);
         row_data.push_back(rng_state);
      end else begin
         row_data.push_back(32'h0);                  // Unused by GET
      end
   endtask

   task automatic build_table();
      // Word order on channel 1
      for (int i = 0; i < 3; i++) add_row($sformatf("order_put%0d", i), 1, 0, 0, 1);
      for (int i = 0; i < 3; i++) add_row($sformatf("order_get%0d", i), 0, 0, 0, 1);
      // Interleaved PUTs, GETs in another channel order
      for (int i = 0; i < 8; i++) begin
         add_row($sformatf("iso_put%0d_ch%0d", i, i % 4), 1, 0, 0, i % 4);
      end
      for (int i = 0; i < 8; i++) begin
         add_row($sformatf("iso_get%0d_ch%0d", i, (i * 3 + 2) % 4), 0, 0, 0, (i * 3 + 2) % 4);
      end
      // Fill channel 3, one dropped PUT, drain, then a GET on empty
      for (int i = 0; i < DEPTH; i++) add_row($sformatf("full_put%0d", i), 1, 0, 0, 3);
      add_row("full_nput_drop", 1, 1, 0, 3);
      for (int i = 0; i < DEPTH; i++) add_row($sformatf("full_get%0d", i), 0, 0, 0, 3);
      add_row("empty_nget", 0, 1, 0, 3);
      // Control word read back as data
      add_row("tag_cput", 1, 0, 1, 2);
      add_row("tag_dget", 0, 0, 0, 2);
      // Address past the last channel
      for (int i = 0; i < NCH; i++) add_row($sformatf("oor_put_ch%0d", i), 1, 0, 0, i);
      add_row("oor_nput_ch5", 1, 1, 0, 5);
      for (int i = 0; i < NCH; i++) add_row($sformatf("oor_get_ch%0d", i), 0, 0, 0, i);
      // Every queue empty again, no stray word left behind
      for (int i = 0; i < NCH; i++) add_row($sformatf("oor_nget_ch%0d", i), 0, 1, 0, i);
   endtask

   // Reference model over the whole table
   task automatic compute_expected();
      mbox_pkg::mbox_entry_t ent;
      logic [31:0]           latch;
      logic [NCH-1:0]        err;
      int                    ch;
      latch = '0;
      err   = '0;
      for (int r = 0; r < row_name.size(); r++) begin
         ch = row_ch[r];
         if (row_put[r]) begin
            if (ch < NCH && model_q[ch].size() < DEPTH) begin
               ent.data = row_data[r];
               ent.tag  = row_ctl[r];
               model_q[ch].push_back(ent);
               latch = '0;                           // Acked PUT brings zero read data
            end
         end else if (ch < NCH && model_q[ch].size() > 0) begin
            ent = model_q[ch].pop_front();
            if (ent.tag != row_ctl[r]) begin
               err[ch] = 1'b1;                       // Sticky per channel
            end
            latch = ent.data;
         end
         // Unacked non-blocking rows keep the latch
         exp_mx.push_back(latch);
         exp_err.push_back(err);
      end
   endtask

   // Sample fb_o away from the clock edge
   task automatic wait_feedback(input int r);
      bit seen;
      seen = 1'b0;
      for (int k = 0; k < FB_WAIT && !seen; k++) begin
         @(negedge gclk);
         if (fb_o) seen = 1'b1;
      end
      if (!seen) begin
         errors++;
         $display("Row %s: fb_o stayed low for %0d cycles", row_name[r], FB_WAIT);
      end
   endtask

   // Watchdog, 20 cycles per row plus reset
   initial begin
      wait (table_ready);
      #((row_name.size() * 20 + 8) * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", row_name.size() * 20 + 8);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      grst   = 1'b1;
      dena_i = 1'b0;
      opc_i  = OPC_NOP;
      imm_i  = '0;
      opa_i  = '0;
      build_table();
      compute_expected();
      table_ready = 1'b1;

      repeat (3) @(posedge gclk);
      grst <= 1'b0;
      @(negedge gclk);
      // State straight after reset
      checks++;
      if (fb_o !== 1'b1) begin
         errors++;
         $display("Error: reset fb_o expected 1 actual %b", fb_o);
      end
      checks++;
      if (mx_o !== 32'h0) begin
         errors++;
         $display("Error: reset mx_o expected %h actual %h", 32'h0, mx_o);
      end
      checks++;
      if (err_o !== '0) begin
         errors++;
         $display("Error: reset err_o expected %b actual %b", {NCH{1'b0}}, err_o);
      end

      for (int r = 0; r < row_name.size(); r++) begin
         @(posedge gclk);
         dena_i <= 1'b1;                             // Instruction taken on next edge
         opc_i  <= row_put[r] ? OPC_PUT : OPC_GET;
         imm_i  <= make_imm(row_put[r], row_nblk[r], row_ctl[r], row_ch[r]);
         opa_i  <= row_data[r];
         @(posedge gclk);
         dena_i <= 1'b0;
         wait_feedback(r);
         @(posedge gclk);
         dena_i <= 1'b1;                             // NOP advance loads mx_o
         opc_i  <= OPC_NOP;
         @(posedge gclk);
         dena_i <= 1'b0;
         @(negedge gclk);
         checks++;
         if (mx_o !== exp_mx[r]) begin
            errors++;
            $display("Error: %s mx_o expected %h actual %h", row_name[r], exp_mx[r], mx_o);
         end
         checks++;
         if (err_o !== exp_err[r]) begin
            errors++;
            $display("Error: %s err_o expected %b actual %b", row_name[r], exp_err[r], err_o);
         end
      end

      repeat (2) @(posedge gclk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* list.f */
common/xsl_bus_pkg.sv
common/mbox_pkg.sv
xslif/xsl_link.sv
source/chan_decode.sv
source/mbox_chan.sv
source/resp_merge.sv
source/xsl_subsys_top.sv
tb/tb_xsl_subsys.sv
